// File: Makefile
# Verilator build and run of the boundary scan testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f sim.f --top-module aib_bscan_tb \
		-o aib_bscan_tb
	./obj_dir/aib_bscan_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/aib_bscan_cell.sv
//////////////////////////////////////////////////////////////////////
// scan outputs change on the falling clock edge
// the rx register captures pads on every cycle that rx_scanen is low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module aib_bscan_cell (
   input  logic                       jtag_clkdr_in, // boundary scan clock
   input  logic                       rst_n,         // async, active low
   input  aib_bscan_pkg::bscan_ctrl_t ctrl,          // broadcast controls
   input  aib_bscan_pkg::aib_tx_t     tx_adap,       // tx from adapter
   input  aib_bscan_pkg::aib_rx_t     rx_aib,        // rx from pad
   input  aib_bscan_pkg::aib_rstb_t   rstb_adap,     // resets from adapter
   input  logic                       tx_scan_in,    // from previous cell
   input  logic                       rx_scan_in,
   output aib_bscan_pkg::aib_tx_t     tx_aib,        // tx to pad
   output aib_bscan_pkg::aib_rx_t     rx_adap,       // rx to adapter
   output aib_bscan_pkg::aib_rstb_t   rstb_aib,      // resets to pad
   output logic                       tx_scan_out,   // to next cell
   output logic                       rx_scan_out
);

   localparam int CB = aib_bscan_pkg::CELL_BITS;

   logic [CB-1:0] tx_reg;   // scanned transmit value
   logic [CB-1:0] rx_reg;   // captured receive value
   logic          tx_nreg;  // falling edge copy of tx_reg[0]
   logic          rx_nreg;  // falling edge copy of rx_reg[0]

   // tx register holds unless shifting
   always_ff @(posedge jtag_clkdr_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tx_reg <= '0;
      end
      else if (ctrl.tx_scanen)
      begin
         tx_reg <= {tx_scan_in, tx_reg[CB-1:1]};  // shift towards bit 0
      end
   end

   // rx register shifts or captures the pad inputs
   always_ff @(posedge jtag_clkdr_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_reg <= '0;
      end
      else if (ctrl.rx_scanen)
      begin
         rx_reg <= {rx_scan_in, rx_reg[CB-1:1]};
      end
      else
      begin
         rx_reg <= rx_aib;  // capture, field order as in aib_rx_t
      end
   end

   // half cycle retime so the next cell sees stable data at its rising edge
   always_ff @(negedge jtag_clkdr_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tx_nreg <= 1'b0;
         rx_nreg <= 1'b0;
      end
      else
      begin
         tx_nreg <= tx_reg[0];
         rx_nreg <= rx_reg[0];
      end
   end

   assign tx_scan_out = tx_nreg;
   assign rx_scan_out = rx_nreg;

   // pad side muxing, all combinational
   assign tx_aib  = ctrl.mode ? aib_bscan_pkg::aib_tx_t'(tx_reg) : tx_adap;
   assign rx_adap = rx_aib;  // receive always passes through

   // tap reset drives both pad resets when enabled
   assign rstb_aib = ctrl.rstb_en ? aib_bscan_pkg::aib_rstb_t'({2{ctrl.rstb}})
                                  : rstb_adap;

endmodule

// File: design/aib_bscan_chain.sv
//////////////////////////////////////////////////////////////////////
// channel NUM_CH-1 is nearest the scan input, channel 0 drives scan out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module aib_bscan_chain #(
   parameter int NUM_CH = 4  // channels in the chain
) (
   input  logic                                    jtag_clkdr_in,
   input  logic                                    rst_n,
   input  aib_bscan_pkg::bscan_ctrl_t              ctrl,
   input  aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0]   tx_adap,
   input  aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0]   rx_aib,
   input  aib_bscan_pkg::aib_rstb_t [NUM_CH-1:0]   rstb_adap,
   input  logic                                    tx_scan_in,  // serial tx in
   input  logic                                    rx_scan_in,  // serial rx in
   input  logic                                    last_bs_in,  // loopback in
   output aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0]   tx_aib,
   output aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0]   rx_adap,
   output aib_bscan_pkg::aib_rstb_t [NUM_CH-1:0]   rstb_aib,
   output logic                                    tx_scan_out,
   output logic                                    rx_scan_out,
   output logic                                    jtag_clkdr_out, // clock feed-through
   output logic                                    last_bs_out     // loopback to ssm
);

   // link k+1 feeds channel k, link 0 leaves the chain
   wire [NUM_CH:0] tx_link;
   wire [NUM_CH:0] rx_link;

   assign tx_link[NUM_CH] = tx_scan_in;
   assign rx_link[NUM_CH] = rx_scan_in;

   for (genvar k = 0; k < NUM_CH; k++)
   begin : g_ch
      aib_bscan_cell i_cell (
         .jtag_clkdr_in (jtag_clkdr_in),
         .rst_n         (rst_n),
         .ctrl          (ctrl),          // same controls for all cells
         .tx_adap       (tx_adap[k]),
         .rx_aib        (rx_aib[k]),
         .rstb_adap     (rstb_adap[k]),
         .tx_scan_in    (tx_link[k+1]),
         .rx_scan_in    (rx_link[k+1]),
         .tx_aib        (tx_aib[k]),
         .rx_adap       (rx_adap[k]),
         .rstb_aib      (rstb_aib[k]),
         .tx_scan_out   (tx_link[k]),
         .rx_scan_out   (rx_link[k])
      );
   end

   assign tx_scan_out = tx_link[0];
   assign rx_scan_out = rx_link[0];

   assign jtag_clkdr_out = jtag_clkdr_in;  // straight through, no gating
   assign last_bs_out    = last_bs_in;

endmodule

// File: design/aib_bscan_pkg.sv
//////////////////////////////////////////////////////////////////////
// struct field order fixes the bit order of every cell scan register
// field 0 of each bundle is the bit shifted out first
//////////////////////////////////////////////////////////////////////
package aib_bscan_pkg;

   // register bits per cell on each of the tx and rx scan paths
   localparam int CELL_BITS = 4;

   // one channel of transmit signals, adapter side and pad side alike
   typedef struct packed {
      logic itxen;       // output enable to the pad, msb
      logic idat0;       // sdr data 0
      logic idat1;       // sdr data 1
      logic async_data;  // async data, lsb and first out
   } aib_tx_t;

   // one channel of receive signals from the pad
   typedef struct packed {
      logic odat0;       // sync data 0
      logic odat1;       // sync data 1
      logic oclk;        // differential clock as seen by the rx buffer
      logic odat_asyn;   // async data, lsb
   } aib_rx_t;

   // pad reset pair, both active low
   typedef struct packed {
      logic anlg_rstb;   // analog reset
      logic dig_rstb;    // digital reset
   } aib_rstb_t;

   // control bundle broadcast to every cell in the chain
   typedef struct packed {
      logic tx_scanen;   // shift dr on tx path
      logic rx_scanen;   // shift dr on rx path, low means capture
      logic mode;        // jtag mode, scanned tx drives the pads
      logic rstb_en;     // tap reset overrides pad resets
      logic rstb;        // tap reset value, active low
   } bscan_ctrl_t;

endpackage

// File: design/aib_bscan_top.sv
//////////////////////////////////////////////////////////////////////
// no tap here, a scan is started by a single start pulse
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module aib_bscan_top #(
   parameter int NUM_CH = 4  // channel count, passed to sequencer and chain
) (
   input  logic                                    jtag_clkdr_in,
   input  logic                                    rst_n,
   input  aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0]   tx_adap,      // from adapter
   output aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0]   tx_aib,       // to pads
   input  aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0]   rx_aib,       // from pads
   output aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0]   rx_adap,      // to adapter
   input  aib_bscan_pkg::aib_rstb_t [NUM_CH-1:0]   rstb_adap,
   output aib_bscan_pkg::aib_rstb_t [NUM_CH-1:0]   rstb_aib,
   input  logic                                    jtag_mode,    // levels
   input  logic                                    jtag_rstb_en,
   input  logic                                    jtag_rstb,
   input  logic                                    last_bs_in,
   output logic                                    last_bs_out,
   output logic                                    jtag_clkdr_out,
   input  logic                                    start,
   input  aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0]   tx_pattern,
   output logic                                    busy,
   output logic                                    done,
   output aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0]   rx_word
);

   aib_bscan_pkg::bscan_ctrl_t ctrl;  // broadcast to all cells
   logic tx_scan_in;
   logic rx_scan_in;
   logic tx_scan_out;
   logic rx_scan_out;

   bscan_dr_seq #(
      .NUM_CH (NUM_CH)
   ) i_seq (
      .jtag_clkdr_in (jtag_clkdr_in),
      .rst_n         (rst_n),
      .start         (start),
      .tx_pattern    (tx_pattern),
      .jtag_mode     (jtag_mode),
      .jtag_rstb_en  (jtag_rstb_en),
      .jtag_rstb     (jtag_rstb),
      .tx_scan_out   (tx_scan_out),
      .rx_scan_out   (rx_scan_out),
      .ctrl          (ctrl),
      .tx_scan_in    (tx_scan_in),
      .rx_scan_in    (rx_scan_in),
      .busy          (busy),
      .done          (done),
      .rx_word       (rx_word)
   );

   aib_bscan_chain #(
      .NUM_CH (NUM_CH)
   ) i_chain (
      .jtag_clkdr_in  (jtag_clkdr_in),
      .rst_n          (rst_n),
      .ctrl           (ctrl),
      .tx_adap        (tx_adap),
      .rx_aib         (rx_aib),
      .rstb_adap      (rstb_adap),
      .tx_scan_in     (tx_scan_in),
      .rx_scan_in     (rx_scan_in),
      .last_bs_in     (last_bs_in),
      .tx_aib         (tx_aib),
      .rx_adap        (rx_adap),
      .rstb_aib       (rstb_aib),
      .tx_scan_out    (tx_scan_out),
      .rx_scan_out    (rx_scan_out),
      .jtag_clkdr_out (jtag_clkdr_out),
      .last_bs_out    (last_bs_out)
   );

endmodule

// File: design/bscan_dr_seq.sv
//////////////////////////////////////////////////////////////////////
// start is ignored while busy, done follows start after 1+W+1 cycles
// rx_word is only valid from the done pulse on
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module bscan_dr_seq #(
   parameter int NUM_CH = 4
) (
   input  logic                                   jtag_clkdr_in,
   input  logic                                   rst_n,
   input  logic                                   start,        // one cycle pulse
   input  aib_bscan_pkg::aib_tx_t [NUM_CH-1:0]    tx_pattern,   // field k for channel k
   input  logic                                   jtag_mode,
   input  logic                                   jtag_rstb_en,
   input  logic                                   jtag_rstb,
   input  logic                                   tx_scan_out,  // from chain, falling edge reg
   input  logic                                   rx_scan_out,
   output aib_bscan_pkg::bscan_ctrl_t             ctrl,
   output logic                                   tx_scan_in,
   output logic                                   rx_scan_in,
   output logic                                   busy,
   output logic                                   done,
   output aib_bscan_pkg::aib_rx_t [NUM_CH-1:0]    rx_word       // field k from channel k
);

   localparam int W     = NUM_CH * aib_bscan_pkg::CELL_BITS;  // chain length per path
   localparam int CNT_W = $clog2(W);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_CAPT,   // rx registers load the pads
      ST_SHIFT   // W shift cycles
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] bit_cnt;     // shift cycle index
   logic [W-1:0]     tx_sh;       // outgoing pattern, bit 0 first
   logic [W-2:0]     rx_sh;       // incoming bits, last one goes straight to rx_word
   logic             shifting;
   logic             last_shift;
   logic             accept;      // start taken this cycle

   assign shifting   = (state == ST_SHIFT);
   assign last_shift = shifting && (bit_cnt == CNT_W'(W - 1));
   assign accept     = (state == ST_IDLE) && start;

   always_ff @(posedge jtag_clkdr_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= ST_IDLE;
         bit_cnt <= '0;
         done    <= 1'b0;
         rx_word <= '0;
      end
      else
      begin
         done <= last_shift;  // one cycle after the last shift
         case (state)
            ST_IDLE:
            begin
               if (start)
               begin
                  state <= ST_CAPT;
               end
            end
            ST_CAPT:
            begin
               state   <= ST_SHIFT;
               bit_cnt <= '0;
            end
            ST_SHIFT:
            begin
               bit_cnt <= bit_cnt + CNT_W'(1);
               if (last_shift)
               begin
                  state   <= ST_IDLE;
                  rx_word <= {rx_scan_out, rx_sh};  // first bit in lands in channel 0 lsb
               end
            end
            default:
            begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // pattern and collect registers, no reset
   always_ff @(posedge jtag_clkdr_in)
   begin
      if (accept)
      begin
         tx_sh <= tx_pattern;  // loaded before capture, stable across the scan
      end
      else if (shifting)
      begin
         tx_sh <= {tx_scan_out, tx_sh[W-1:1]};  // old chain contents recirculate in
         rx_sh <= {rx_scan_out, rx_sh[W-2:1]};
      end
   end

   assign tx_scan_in = tx_sh[0];  // last field bit ends up at channel NUM_CH-1 msb
   assign rx_scan_in = 1'b0;      // rx chain fills with zeros behind the data

   assign ctrl.tx_scanen = shifting;
   assign ctrl.rx_scanen = shifting;
   assign ctrl.mode      = jtag_mode;     // levels copied from the top inputs
   assign ctrl.rstb_en   = jtag_rstb_en;
   assign ctrl.rstb      = jtag_rstb;

   assign busy = (state != ST_IDLE);

endmodule

// File: sim.f
design/aib_bscan_pkg.sv
design/aib_bscan_cell.sv
design/aib_bscan_chain.sv
design/bscan_dr_seq.sv
design/aib_bscan_top.sv
verification/aib_bscan_asserts.sv
verification/aib_bscan_checker.sv
verification/aib_bscan_tb.sv

// File: verification/aib_bscan_asserts.sv
//////////////////////////////////////////////////////////////////////
// bound into bscan_dr_seq, checks the sequencer control handshake
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module aib_bscan_asserts (
   input logic                       clk,
   input logic                       rst_n,
   input logic                       start,
   input logic                       busy,
   input logic                       done,
   input aib_bscan_pkg::bscan_ctrl_t ctrl
);

   int assert_errs = 0;  // failed assertions so far

   // done is a single cycle pulse
   a_done_width : assert property (@(posedge clk) disable iff (!rst_n)
      done |=> !done)
      else
      begin
         $error("done held high for more than one cycle");
         assert_errs++;
      end

   // no shifting outside a scan
   a_idle_scanen : assert property (@(posedge clk) disable iff (!rst_n)
      !busy |-> (!ctrl.tx_scanen && !ctrl.rx_scanen))
      else
      begin
         $error("scan enable high while sequencer idle");
         assert_errs++;
      end

   // capture state is busy with scan enables low, a start while busy must not re-enter it
   a_start_busy : assert property (@(posedge clk) disable iff (!rst_n)
      (busy && start) |=> !(busy && !ctrl.tx_scanen))
      else
      begin
         $error("start taken while sequencer busy");
         assert_errs++;
      end

endmodule

bind bscan_dr_seq aib_bscan_asserts i_asserts (
   .clk   (jtag_clkdr_in),
   .rst_n (rst_n),
   .start (start),
   .busy  (busy),
   .done  (done),
   .ctrl  (ctrl)
);

// File: verification/aib_bscan_checker.sv
//////////////////////////////////////////////////////////////////////
// compares on the falling edge, done expected 18 cycles after start
// valid for NUM_CH 4 only
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module aib_bscan_checker (
   input logic        clk,
   input logic        chk_en,         // compare pad and adapter outputs
   input logic        word_en,        // compare rx_word at done
   input logic [15:0] exp_tx,
   input logic [15:0] exp_rx,
   input logic [7:0]  exp_rstb,
   input logic        exp_last_bs,
   input logic [15:0] exp_word,
   input logic [15:0] tx_aib,
   input logic [15:0] rx_adap,
   input logic [7:0]  rstb_aib,
   input logic        last_bs_out,
   input logic        jtag_clkdr_out,
   input logic        start,
   input logic        busy,
   input logic        done,
   input logic [15:0] rx_word
);

   localparam int SCAN_CYCLES = 18;  // capture + 16 shifts + done

   int   value_errs = 0;
   int   proto_errs = 0;
   int   cyc_cnt    = 0;
   logic pending    = 1'b0;  // accepted start waiting for done

   always @(negedge clk)
   begin
      if (chk_en)
      begin
         if (tx_aib !== exp_tx)
         begin
            $display("Error at %0t: tx_aib %h, expected %h", $time, tx_aib, exp_tx);
            value_errs++;
         end
         if (rx_adap !== exp_rx)
         begin
            $display("Error at %0t: rx_adap %h, expected %h", $time, rx_adap, exp_rx);
            value_errs++;
         end
         if (rstb_aib !== exp_rstb)
         begin
            $display("Error at %0t: rstb_aib %h, expected %h", $time, rstb_aib, exp_rstb);
            value_errs++;
         end
         if (last_bs_out !== exp_last_bs)
         begin
            $display("Error at %0t: last_bs_out %b, expected %b", $time,
                     last_bs_out, exp_last_bs);
            value_errs++;
         end
         if (busy !== 1'b0 || done !== 1'b0)
         begin
            $display("Error at %0t: busy %b done %b while idle", $time, busy, done);
            value_errs++;
         end
      end
      if (pending)
         cyc_cnt++;
      if (done === 1'b1)
      begin
         if (!pending)
         begin
            $display("done pulse at %0t without a preceding start", $time);
            proto_errs++;
         end
         else if (cyc_cnt != SCAN_CYCLES)
         begin
            $display("Error at %0t: done after %0d cycles, expected %0d", $time,
                     cyc_cnt, SCAN_CYCLES);
            value_errs++;
         end
         if (word_en && rx_word !== exp_word)
         begin
            $display("Error at %0t: rx_word %h, expected %h", $time, rx_word, exp_word);
            value_errs++;
         end
         pending = 1'b0;
      end
      // a start seen while idle is taken at the next rising edge
      if (start === 1'b1 && busy === 1'b0 && !pending)
      begin
         pending = 1'b1;
         cyc_cnt = 0;
      end
   end

   // feed-through must be low in the low phase
   always @(negedge clk)
   begin
      #1;
      if (jtag_clkdr_out !== 1'b0)
      begin
         $display("Error at %0t: jtag_clkdr_out high in low clock phase", $time);
         value_errs++;
      end
   end

   // feed-through must be high in the high phase
   always @(posedge clk)
   begin
      #1;
      if (jtag_clkdr_out !== 1'b1)
      begin
         $display("Error at %0t: jtag_clkdr_out low in high clock phase", $time);
         value_errs++;
      end
   end

endmodule

// File: verification/aib_bscan_golden.txt
// tx_adap rx_aib rstb_adap ctl(mode,rstb_en,rstb,last_bs) start(0,1,2=twice) tx_pattern
// exp_tx_aib exp_rx_adap exp_rstb_aib exp_rx_word, hex digit k is channel k
a5c3 1234 e4 b 0 0000 0000 1234 e4 0000
5a3c fedc 1b 0 0 0000 5a3c fedc 1b 0000
0f0f 8421 ff 5 0 0000 0f0f 8421 00 0000
f0f0 1248 00 6 0 0000 f0f0 1248 ff 0000
1111 9c6b 36 a 1 3ca5 3ca5 9c6b 36 9c6b
7e81 0000 36 2 0 0000 7e81 0000 36 0000
7e81 5555 36 a 0 0000 3ca5 5555 36 0000
0000 2b7e 36 b 2 f00d f00d 2b7e 36 2b7e
c0de a5a5 36 3 1 6996 c0de a5a5 36 a5a5
c0de 0ff0 36 a 0 0000 6996 0ff0 36 0000
0000 ffff c9 e 1 ffff ffff ffff ff ffff
0000 8001 c9 8 1 0001 0001 8001 c9 8001

// File: verification/aib_bscan_tb.sv
//////////////////////////////////////////////////////////////////////
// vectors come from the golden file, NUM_CH fixed at 4 channels
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module aib_bscan_tb;

   localparam int NUM_CH  = 4;
   localparam int NW      = 10;  // words per golden line
   localparam int NVEC    = 12;
   localparam int TIMEOUT = 40;  // cycles to wait for done

   logic clk;
   logic rst_n;
   aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0] tx_adap;
   aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0] tx_aib;
   aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0] rx_aib;
   aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0] rx_adap;
   aib_bscan_pkg::aib_rstb_t [NUM_CH-1:0] rstb_adap;
   aib_bscan_pkg::aib_rstb_t [NUM_CH-1:0] rstb_aib;
   aib_bscan_pkg::aib_tx_t   [NUM_CH-1:0] tx_pattern;
   aib_bscan_pkg::aib_rx_t   [NUM_CH-1:0] rx_word;
   logic jtag_mode;
   logic jtag_rstb_en;
   logic jtag_rstb;
   logic last_bs_in;
   logic last_bs_out;
   logic jtag_clkdr_out;
   logic start;
   logic busy;
   logic done;
   logic chk_en;
   logic word_en;
   logic [15:0] exp_tx;
   logic [15:0] exp_rx;
   logic [7:0]  exp_rstb;
   logic        exp_last_bs;
   logic [15:0] exp_word;
   logic [15:0] vec_mem [NVEC*NW];
   int          timeouts;
   int          v;

   initial clk = 1'b0;
   always #4 clk = ~clk;  // 8 ns period

   aib_bscan_top #(
      .NUM_CH (NUM_CH)
   ) i_dut (
      .jtag_clkdr_in  (clk),
      .rst_n          (rst_n),
      .tx_adap        (tx_adap),
      .tx_aib         (tx_aib),
      .rx_aib         (rx_aib),
      .rx_adap        (rx_adap),
      .rstb_adap      (rstb_adap),
      .rstb_aib       (rstb_aib),
      .jtag_mode      (jtag_mode),
      .jtag_rstb_en   (jtag_rstb_en),
      .jtag_rstb      (jtag_rstb),
      .last_bs_in     (last_bs_in),
      .last_bs_out    (last_bs_out),
      .jtag_clkdr_out (jtag_clkdr_out),
      .start          (start),
      .tx_pattern     (tx_pattern),
      .busy           (busy),
      .done           (done),
      .rx_word        (rx_word)
   );

   aib_bscan_checker i_chk (
      .clk            (clk),
      .chk_en         (chk_en),
      .word_en        (word_en),
      .exp_tx         (exp_tx),
      .exp_rx         (exp_rx),
      .exp_rstb       (exp_rstb),
      .exp_last_bs    (exp_last_bs),
      .exp_word       (exp_word),
      .tx_aib         (tx_aib),
      .rx_adap        (rx_adap),
      .rstb_aib       (rstb_aib),
      .last_bs_out    (last_bs_out),
      .jtag_clkdr_out (jtag_clkdr_out),
      .start          (start),
      .busy           (busy),
      .done           (done),
      .rx_word        (rx_word)
   );

   // pulse start once, twice for code 2 (second one lands while busy)
   task automatic pulse_start(input int count);
      for (int i = 0; i < count; i++)
      begin
         @(posedge clk);
         start <= 1'b1;
         @(posedge clk);
         start <= 1'b0;
      end
   endtask

   // apply one golden line, run its scan if any, then let the checker compare
   task automatic run_vector(input int idx);
      int b;
      int cyc;
      b = idx * NW;
      @(posedge clk);
      tx_adap      <= vec_mem[b];
      rx_aib       <= vec_mem[b+1];
      rstb_adap    <= vec_mem[b+2][7:0];
      jtag_mode    <= vec_mem[b+3][3];
      jtag_rstb_en <= vec_mem[b+3][2];
      jtag_rstb    <= vec_mem[b+3][1];
      last_bs_in   <= vec_mem[b+3][0];
      exp_last_bs  <= vec_mem[b+3][0];
      tx_pattern   <= vec_mem[b+5];
      exp_tx       <= vec_mem[b+6];
      exp_rx       <= vec_mem[b+7];
      exp_rstb     <= vec_mem[b+8][7:0];
      exp_word     <= vec_mem[b+9];
      word_en      <= (vec_mem[b+4] != 16'd0);
      chk_en       <= (vec_mem[b+4] == 16'd0);  // pads still show old registers
      if (vec_mem[b+4] != 16'd0)
      begin
         pulse_start(int'(vec_mem[b+4]));
         cyc = 0;
         while (done !== 1'b1 && cyc < TIMEOUT)
         begin
            @(negedge clk);
            cyc++;
         end
         if (done !== 1'b1)
         begin
            $display("timeout: no done within %0d cycles in vector %0d", TIMEOUT, idx);
            timeouts++;
         end
         @(posedge clk);
         chk_en <= 1'b1;  // scanned registers now final
      end
   endtask

   initial
   begin
      rst_n        = 1'b0;
      tx_adap      = '0;
      rx_aib       = '0;
      rstb_adap    = '0;
      tx_pattern   = '0;
      jtag_mode    = 1'b0;
      jtag_rstb_en = 1'b0;
      jtag_rstb    = 1'b0;
      last_bs_in   = 1'b0;
      start        = 1'b0;
      chk_en       = 1'b0;
      word_en      = 1'b0;
      exp_tx       = '0;
      exp_rx       = '0;
      exp_rstb     = '0;
      exp_last_bs  = 1'b0;
      exp_word     = '0;
      timeouts     = 0;
      $readmemh("verification/aib_bscan_golden.txt", vec_mem);
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      for (v = 0; v < NVEC && timeouts == 0; v++)
         run_vector(v);
      @(posedge clk);
      chk_en <= 1'b0;
      repeat (2) @(posedge clk);
      $display("value errors %0d, protocol errors %0d, assertion errors %0d, timeouts %0d",
               i_chk.value_errs, i_chk.proto_errs, i_dut.i_seq.i_asserts.assert_errs,
               timeouts);
      if (i_chk.value_errs + i_chk.proto_errs + i_dut.i_seq.i_asserts.assert_errs
          + timeouts == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
